// ==== src/flash_cmd_pkg.sv ====
package flash_cmd_pkg;

    // flash protocol widths
    localparam int ADDR_W  = 24;
    localparam int DATA_W  = 32;
    localparam int OPC_W   = 8;
    localparam int FRAME_W = OPC_W + ADDR_W + DATA_W;

    // command bytes
    localparam logic [OPC_W-1:0] OPC_READ = 8'h03;
    localparam logic [OPC_W-1:0] OPC_WREN = 8'h06;
    localparam logic [OPC_W-1:0] OPC_PP   = 8'h02;
    localparam logic [OPC_W-1:0] OPC_SE   = 8'h20;
    localparam logic [OPC_W-1:0] OPC_RDSR = 8'h05;

    localparam int SR_WIP_BIT = 0;                      // write in progress

    // command frame as sent on the wire, opcode first
    typedef struct packed {
        logic [OPC_W-1:0]  opcode;
        logic [ADDR_W-1:0] address;
        logic [DATA_W-1:0] data;
    } frame_fields_t;

    // built as fields by the sequencer, shifted raw by the shifter
    typedef union packed {
        frame_fields_t      f;
        logic [FRAME_W-1:0] raw;
    } flash_frame_t;

endpackage

// ==== src/flash_ctrl_pkg.sv ====
package flash_ctrl_pkg;

    // operation sequencer states
    typedef enum logic [2:0] {
        IDLE,
        WREN,
        CMD,
        POLL,
        DONE
    } seq_state_t;

    // host request
    typedef enum logic [1:0] {
        OP_READ,
        OP_WRITE,
        OP_ERASE
    } host_op_t;

    localparam int LEN_W = 7;

    // frame lengths in bits, opcode included
    localparam logic [LEN_W-1:0] LEN_WREN = 7'd8;
    localparam logic [LEN_W-1:0] LEN_READ = 7'd64;    // opcode, address, 32 bits in
    localparam logic [LEN_W-1:0] LEN_PP   = 7'd64;
    localparam logic [LEN_W-1:0] LEN_SE   = 7'd32;
    localparam logic [LEN_W-1:0] LEN_RDSR = 7'd16;    // opcode, status byte in

endpackage

// ==== src/shift_if.sv ====
`timescale 1ns/1ps

interface shift_if;
    import flash_cmd_pkg::*;
    import flash_ctrl_pkg::*;

    logic              go;        // one cycle, shifter idle only
    flash_frame_t      frame;
    logic [LEN_W-1:0]  len;
    logic              done;      // one cycle, cs already high
    logic [DATA_W-1:0] rx;        // last 32 bits received

    modport master (
        output go, frame, len,
        input  done, rx
    );

    modport slave (
        input  go, frame, len,
        output done, rx
    );

endinterface

// ==== src/spi_shifter.sv ====
`timescale 1ns/1ps

module spi_shifter #(
    parameter int CLK_DIV = 2
) (
    input  logic   i_clk,
    input  logic   i_reset,
    shift_if.slave sif,
    output logic   spi_cs_n,
    output logic   spi_sck,
    output logic   spi_mosi,
    input  logic   spi_miso
);
    import flash_cmd_pkg::*;
    import flash_ctrl_pkg::*;

    localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(CLK_DIV - 1);

    logic [DIV_W-1:0] div_cnt;
    logic [LEN_W-1:0] bit_cnt;      // bits still to clock
    logic             mosi_q;
    logic             done_q;
    flash_frame_t     shreg;
    logic             div_tick;
    logic             start_frame;
    logic             rise;

    assign div_tick    = (div_cnt == DIV_LAST);
    assign start_frame = spi_cs_n && sif.go;
    assign rise        = !spi_cs_n && div_tick && (bit_cnt != '0) && !spi_sck;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            spi_cs_n <= 1'b1;
            spi_sck  <= 1'b0;
            mosi_q   <= 1'b0;
            done_q   <= 1'b0;
            bit_cnt  <= '0;
            div_cnt  <= '0;
        end else begin
            done_q <= 1'b0;
            if (spi_cs_n) begin
                if (sif.go) begin
                    spi_cs_n <= 1'b0;
                    bit_cnt  <= sif.len;
                    div_cnt  <= '0;
                    mosi_q   <= sif.frame.raw[FRAME_W-1];    // first bit ready before sck rises
                end
            end else if (div_tick) begin
                div_cnt <= '0;
                if (bit_cnt == '0) begin                    // tail after the last fall
                    spi_cs_n <= 1'b1;
                    mosi_q   <= 1'b0;
                    done_q   <= 1'b1;
                end else if (rise) begin
                    spi_sck <= 1'b1;
                end else begin
                    spi_sck <= 1'b0;
                    bit_cnt <= bit_cnt - 1'b1;
                    mosi_q  <= shreg.raw[FRAME_W-1];
                end
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    // out from the top, miso in at the bottom on each rising edge
    always_ff @(posedge i_clk) begin
        if (start_frame) begin
            shreg.raw <= sif.frame.raw;
        end else if (rise) begin
            shreg.raw <= {shreg.raw[FRAME_W-2:0], spi_miso};
        end
    end

    assign spi_mosi = mosi_q;
    assign sif.done = done_q;
    assign sif.rx   = shreg.raw[DATA_W-1:0];

    // mode 0 idle level on the bus
    a_sck_idle_low: assert property (@(posedge i_clk) disable iff (i_reset)
        spi_cs_n |-> !spi_sck);

    // the sequencer must wait for done before the next frame
    a_go_when_idle: assert property (@(posedge i_clk) disable iff (i_reset)
        sif.go |-> spi_cs_n);

endmodule

// ==== src/cmd_sequencer.sv ====
`timescale 1ns/1ps

module cmd_sequencer (
    input  logic                             i_clk,
    input  logic                             i_reset,
    input  logic                             start,
    input  flash_ctrl_pkg::host_op_t         op,
    input  logic [flash_cmd_pkg::ADDR_W-1:0] address,
    input  logic [flash_cmd_pkg::DATA_W-1:0] wr_word,
    input  logic                             ack,
    output logic                             busy,
    output logic                             valid,
    output logic [flash_cmd_pkg::DATA_W-1:0] rd_word,
    shift_if.master                          sif
);
    import flash_cmd_pkg::*;
    import flash_ctrl_pkg::*;

    seq_state_t        state;
    host_op_t          op_q;
    logic [ADDR_W-1:0] addr_q;
    logic [DATA_W-1:0] wdata_q;
    logic              pending;      // frame out, waiting for done
    logic              issue;
    flash_frame_t      nxt_frame;
    logic [LEN_W-1:0]  nxt_len;

    function automatic flash_frame_t build_frame(
        input logic [OPC_W-1:0]  opc,
        input logic [ADDR_W-1:0] adr,
        input logic [DATA_W-1:0] dat
    );
        flash_frame_t fr;
        fr.f.opcode  = opc;
        fr.f.address = adr;
        fr.f.data    = dat;
        return fr;
    endfunction

    assign issue = !pending && (state inside {WREN, CMD, POLL});

    always_comb begin
        nxt_frame = build_frame(OPC_RDSR, '0, '0);
        nxt_len   = LEN_RDSR;
        case (state)
            WREN: begin
                nxt_frame = build_frame(OPC_WREN, '0, '0);
                nxt_len   = LEN_WREN;
            end
            CMD: begin
                case (op_q)
                    OP_READ: begin
                        nxt_frame = build_frame(OPC_READ, addr_q, '0);
                        nxt_len   = LEN_READ;
                    end
                    OP_WRITE: begin
                        nxt_frame = build_frame(OPC_PP, addr_q, wdata_q);
                        nxt_len   = LEN_PP;
                    end
                    default: begin
                        nxt_frame = build_frame(OPC_SE, addr_q, '0);
                        nxt_len   = LEN_SE;
                    end
                endcase
            end
            default: ;                                      // poll frame
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (state == IDLE && start) begin
            op_q    <= op;
            addr_q  <= address;
            wdata_q <= wr_word;
        end
        if (issue) begin
            sif.frame <= nxt_frame;
            sif.len   <= nxt_len;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state   <= IDLE;
            pending <= 1'b0;
            busy    <= 1'b0;
            valid   <= 1'b0;
            rd_word <= '0;
            sif.go  <= 1'b0;
        end else begin
            sif.go <= issue;
            if (issue) begin
                pending <= 1'b1;
            end else if (sif.done) begin
                pending <= 1'b0;
            end
            case (state)
                IDLE: begin
                    if (start) begin
                        busy  <= 1'b1;
                        state <= (op == OP_READ) ? CMD : WREN;
                    end
                end
                WREN: begin
                    if (sif.done) state <= CMD;
                end
                CMD: begin
                    if (sif.done) begin
                        if (op_q == OP_READ) begin
                            rd_word <= sif.rx;
                            busy    <= 1'b0;
                            valid   <= 1'b1;
                            state   <= DONE;
                        end else begin
                            state <= POLL;
                        end
                    end
                end
                POLL: begin
                    if (sif.done && !sif.rx[SR_WIP_BIT]) begin   // flash ready
                        busy  <= 1'b0;
                        valid <= 1'b1;
                        state <= DONE;
                    end
                end
                DONE: begin
                    if (ack) begin
                        valid <= 1'b0;
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    a_valid_busy_excl: assert property (@(posedge i_clk) disable iff (i_reset)
        !(valid && busy));

    // no frame while the host holds a result or nothing is requested
    a_go_in_frame_state: assert property (@(posedge i_clk) disable iff (i_reset)
        sif.go |-> busy && (state inside {WREN, CMD, POLL}));

endmodule

// ==== src/flash_ctrl_top.sv ====
`timescale 1ns/1ps

module flash_ctrl_top #(
    parameter int CLK_DIV = 2       // i_clk cycles per sck half period
) (
    input  logic                             i_clk,
    input  logic                             i_reset,

    // host side
    input  logic                             start,
    input  flash_ctrl_pkg::host_op_t         op,
    input  logic [flash_cmd_pkg::ADDR_W-1:0] address,
    input  logic [flash_cmd_pkg::DATA_W-1:0] wr_word,
    input  logic                             ack,
    output logic                             busy,
    output logic                             valid,
    output logic [flash_cmd_pkg::DATA_W-1:0] rd_word,

    // flash side, spi mode 0
    output logic                             spi_cs_n,
    output logic                             spi_sck,
    output logic                             spi_mosi,
    input  logic                             spi_miso
);

    shift_if i_shift_if ();

    cmd_sequencer i_cmd_sequencer (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .start   (start),
        .op      (op),
        .address (address),
        .wr_word (wr_word),
        .ack     (ack),
        .busy    (busy),
        .valid   (valid),
        .rd_word (rd_word),
        .sif     (i_shift_if.master)
    );

    spi_shifter #(
        .CLK_DIV (CLK_DIV)
    ) i_spi_shifter (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .sif      (i_shift_if.slave),
        .spi_cs_n (spi_cs_n),
        .spi_sck  (spi_sck),
        .spi_mosi (spi_mosi),
        .spi_miso (spi_miso)
    );

endmodule

// ==== sim/spi_flash_model.sv ====
`timescale 1ns/1ps

module spi_flash_model (
    input  logic spi_cs_n,
    input  logic spi_sck,
    input  logic spi_mosi,
    output logic spi_miso
);
    import flash_cmd_pkg::*;

    logic [7:0]        mem [logic [ADDR_W-1:0]];    // missing bytes read as erased
    logic [63:0]       rx_sr;
    logic [DATA_W-1:0] tx_sr;
    logic [OPC_W-1:0]  opc;
    logic              wel;                          // write enable latch
    logic              cs_q;
    logic              sck_q;
    int                bit_cnt;
    int                busy_cnt;                     // status reads left with wip set
    integer            seed;

    function automatic logic [7:0] rd_byte(input logic [ADDR_W-1:0] a);
        return mem.exists(a) ? mem[a] : 8'hFF;
    endfunction

    task automatic start_busy();
        wel      = 1'b0;
        busy_cnt = 1 + ($unsigned($random(seed)) % 5);
    endtask

    // mosi sampled on the rising sck edge
    task automatic take_bit();
        logic [ADDR_W-1:0] a;
        rx_sr = {rx_sr[62:0], spi_mosi};
        bit_cnt++;
        a = rx_sr[ADDR_W-1:0];
        if (bit_cnt == 8) begin
            opc = rx_sr[OPC_W-1:0];
            if (opc == OPC_RDSR) tx_sr = {6'b0, wel, busy_cnt != 0, 24'h0};
        end
        if (bit_cnt == 32 && opc == OPC_READ) begin
            tx_sr = {rd_byte(a), rd_byte(a + 24'd1), rd_byte(a + 24'd2), rd_byte(a + 24'd3)};
        end
    endtask

    // miso changes on the falling sck edge
    task automatic send_bit();
        spi_miso = tx_sr[DATA_W-1];
        tx_sr    = tx_sr << 1;
    endtask

    task automatic end_frame();
        flash_frame_t      fr;
        logic [ADDR_W-1:0] a;
        logic [DATA_W-1:0] d;
        fr.raw   = rx_sr;
        a        = fr.f.address;
        d        = fr.f.data;
        spi_miso = 1'b0;
        if (opc == OPC_WREN && bit_cnt == 8) begin
            wel = 1'b1;
        end else if (opc == OPC_PP && bit_cnt == 64 && wel) begin
            for (int i = 0; i < 4; i++) begin
                mem[a + ADDR_W'(i)] = rd_byte(a + ADDR_W'(i)) & d[DATA_W-1 -: 8];   // bits only clear
                d = d << 8;
            end
            start_busy();
        end else if (opc == OPC_SE && bit_cnt == 32 && wel) begin
            a = {rx_sr[ADDR_W-1:12], 12'h000};
            for (int i = 0; i < 4096; i++) begin
                if (mem.exists(a + ADDR_W'(i))) mem.delete(a + ADDR_W'(i));
            end
            start_busy();
        end else if (opc == OPC_RDSR && bit_cnt == 16 && busy_cnt > 0) begin
            busy_cnt--;
        end
    endtask

    initial begin
        seed     = 64029;
        spi_miso = 1'b0;
        cs_q     = 1'b1;
        sck_q    = 1'b0;
        wel      = 1'b0;
        busy_cnt = 0;
        bit_cnt  = 0;
        opc      = '0;
        rx_sr    = '0;
        tx_sr    = '0;
        forever begin
            @(spi_cs_n or spi_sck);
            if (spi_cs_n === 1'b0 && cs_q !== 1'b0) begin
                bit_cnt = 0;
                opc     = '0;
                rx_sr   = '0;
                tx_sr   = '0;
            end else if (spi_cs_n === 1'b1 && cs_q === 1'b0) begin
                end_frame();
            end else if (spi_cs_n === 1'b0 && spi_sck === 1'b1 && sck_q !== 1'b1) begin
                take_bit();
            end else if (spi_cs_n === 1'b0 && spi_sck === 1'b0 && sck_q === 1'b1) begin
                send_bit();
            end
            cs_q  = spi_cs_n;
            sck_q = spi_sck;
        end
    end

endmodule

// ==== sim/tb_flash_ctrl.sv ====
`timescale 1ns/1ps

module tb_flash_ctrl;
    import flash_cmd_pkg::*;
    import flash_ctrl_pkg::*;

    localparam int TIMEOUT = 20000;                  // cycles per wait
    localparam logic [DATA_W-1:0] W1 = 32'hA5C3_0F96;
    localparam logic [DATA_W-1:0] W2 = 32'h0FF0_3CC3;

    logic              i_clk;
    logic              i_reset;
    logic              start;
    host_op_t          op;
    logic [ADDR_W-1:0] address;
    logic [DATA_W-1:0] wr_word;
    logic              ack;
    logic              busy;
    logic              valid;
    logic [DATA_W-1:0] rd_word;
    logic              spi_cs_n;
    logic              spi_sck;
    logic              spi_mosi;
    logic              spi_miso;

    // one operation per row
    host_op_t          tbl_op[$];
    logic [ADDR_W-1:0] tbl_addr[$];
    logic [DATA_W-1:0] tbl_wdata[$];
    logic [DATA_W-1:0] tbl_exp[$];                   // reads only
    bit                tbl_stress[$];                // extra starts, late ack
    string             tbl_name[$];

    int checks    = 0;
    int errors    = 0;
    int tests     = 0;
    bit timed_out = 1'b0;

    flash_ctrl_top #(
        .CLK_DIV (2)
    ) i_flash_ctrl_top (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .start    (start),
        .op       (op),
        .address  (address),
        .wr_word  (wr_word),
        .ack      (ack),
        .busy     (busy),
        .valid    (valid),
        .rd_word  (rd_word),
        .spi_cs_n (spi_cs_n),
        .spi_sck  (spi_sck),
        .spi_mosi (spi_mosi),
        .spi_miso (spi_miso)
    );

    spi_flash_model i_spi_flash_model (
        .spi_cs_n (spi_cs_n),
        .spi_sck  (spi_sck),
        .spi_mosi (spi_mosi),
        .spi_miso (spi_miso)
    );

    initial begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    task automatic next_cycle();
        @(posedge i_clk);
        #1;
    endtask

    task automatic check_word(input string sig, input logic [DATA_W-1:0] got,
                              input logic [DATA_W-1:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("[FAIL] %0d ns %s got %h expected %h", $time, sig, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string sig, input logic got, input logic exp);
        checks++;
        assert (got === exp) else begin
            $display("[FAIL] %0d ns %s got %b expected %b", $time, sig, got, exp);
            errors++;
        end
    endtask

    task automatic add_row(input host_op_t o, input logic [ADDR_W-1:0] a,
                           input logic [DATA_W-1:0] w, input logic [DATA_W-1:0] e,
                           input bit s, input string n);
        tbl_op.push_back(o);
        tbl_addr.push_back(a);
        tbl_wdata.push_back(w);
        tbl_exp.push_back(e);
        tbl_stress.push_back(s);
        tbl_name.push_back(n);
    endtask

    task automatic load_table();
        add_row(OP_READ,  24'h000100, 32'h0, 32'hFFFF_FFFF, 1'b0, "read_blank");
        add_row(OP_WRITE, 24'h002010, 32'h1234_5678, 32'h0, 1'b0, "prog_other_sector");
        add_row(OP_ERASE, 24'h001000, 32'h0, 32'h0, 1'b0, "erase_sector");
        add_row(OP_WRITE, 24'h001020, W1, 32'h0, 1'b0, "prog_word");
        add_row(OP_READ,  24'h001020, 32'h0, W1, 1'b0, "read_word");
        add_row(OP_WRITE, 24'h001020, W2, 32'h0, 1'b0, "prog_over");
        add_row(OP_READ,  24'h001020, 32'h0, W1 & W2, 1'b0, "read_and");
        add_row(OP_ERASE, 24'h001234, 32'h0, 32'h0, 1'b0, "erase_again");
        add_row(OP_READ,  24'h001020, 32'h0, 32'hFFFF_FFFF, 1'b0, "read_erased");
        add_row(OP_READ,  24'h002010, 32'h0, 32'h1234_5678, 1'b0, "read_other_sector");
        add_row(OP_WRITE, 24'h003008, 32'h55AA_33CC, 32'h0, 1'b1, "prog_ignore_start");
        add_row(OP_READ,  24'h003008, 32'h0, 32'h55AA_33CC, 1'b0, "read_after_stress");
    endtask

    task automatic wait_valid(input string name);
        int cycles;
        cycles = 0;
        while (valid !== 1'b1 && cycles < TIMEOUT) begin
            next_cycle();
            cycles++;
        end
        if (valid !== 1'b1) begin
            $display("timeout, valid did not rise within %0d cycles in %s", TIMEOUT, name);
            errors++;
            timed_out = 1'b1;
        end
    endtask

    // result waits ten cycles, bus must stay idle
    task automatic hold_without_ack();
        for (int n = 0; n < 10; n++) begin
            start = (n == 4);
            next_cycle();
            check_bit("valid", valid, 1'b1);
            check_bit("spi_cs_n", spi_cs_n, 1'b1);
            check_bit("spi_sck", spi_sck, 1'b0);
        end
        start = 1'b0;
    endtask

    task automatic run_row(input int idx);
        int err_start;
        err_start = errors;
        start     = 1'b1;
        op        = tbl_op[idx];
        address   = tbl_addr[idx];
        wr_word   = tbl_wdata[idx];
        next_cycle();
        start = 1'b0;
        check_bit("busy", busy, 1'b1);
        if (tbl_stress[idx]) begin
            repeat (3) begin                         // an erase here would wipe the word
                next_cycle();
                start = 1'b1;
                op    = OP_ERASE;
                next_cycle();
                start = 1'b0;
                check_bit("busy", busy, 1'b1);
            end
        end
        wait_valid(tbl_name[idx]);
        if (!timed_out) begin
            check_bit("busy", busy, 1'b0);
            if (tbl_op[idx] == OP_READ) check_word("rd_word", rd_word, tbl_exp[idx]);
            if (tbl_stress[idx]) hold_without_ack();
            ack = 1'b1;
            next_cycle();
            ack = 1'b0;
            check_bit("valid", valid, 1'b0);
            check_bit("busy", busy, 1'b0);
        end
        tests++;
        $display("test %-20s %s", tbl_name[idx], (errors == err_start) ? "ok" : "error");
    endtask

    initial begin
        i_reset = 1'b1;
        start   = 1'b0;
        op      = OP_READ;
        address = '0;
        wr_word = '0;
        ack     = 1'b0;
        load_table();
        repeat (16) @(posedge i_clk);
        #1;
        i_reset = 1'b0;
        next_cycle();
        check_bit("busy", busy, 1'b0);
        check_bit("valid", valid, 1'b0);
        check_bit("spi_cs_n", spi_cs_n, 1'b1);
        check_bit("spi_sck", spi_sck, 1'b0);
        check_word("rd_word", rd_word, 32'h0);
        tests++;
        $display("test %-20s %s", "reset_state", (errors == 0) ? "ok" : "error");
        for (int i = 0; i < tbl_name.size() && !timed_out; i++) begin
            run_row(i);
        end
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== build.f ====
src/flash_cmd_pkg.sv
src/flash_ctrl_pkg.sv
src/shift_if.sv
src/spi_shifter.sv
src/cmd_sequencer.sv
src/flash_ctrl_top.sv
sim/spi_flash_model.sv
sim/tb_flash_ctrl.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_flash_ctrl
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= TB FAILED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
